// File: sim.f
hw/pool_geom_pkg.sv
hw/pool_ctrl_pkg.sv
hw/pool_ifs.sv
hw/pool_job_ctrl.sv
hw/pool_line_buffer.sv
hw/pool_max_tree.sv
hw/pool_engine.sv
verif/tb_clk_gen.sv
verif/tb_pool_engine.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pool engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_pool_engine -o tb_pool_engine_sim
./obj_dir/tb_pool_engine_sim 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation clean"

// File: verif/tb_pool_engine.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pool_engine;

    // Enough for three 8x8 maps
    localparam int MEM_DEPTH      = 256;
    localparam int OPCODE_TIMEOUT = 16;
    localparam int JOB_TIMEOUT    = 20000;

    logic                   clk;
    logic                   rst;
    pool_ctrl_pkg::opcode_t opcode;
    logic                   opcode_valid;
    logic                   opcode_accept;
    logic                   opcode_complete;
    pool_geom_pkg::pixel_t  datain;
    logic                   datain_valid;
    logic                   datain_ready;
    pool_geom_pkg::pixel_t  dataout;
    logic                   dataout_valid;
    logic                   dataout_ready;

    // Stored images with maps back to back in raster order
    pool_geom_pkg::pixel_t img_mem [MEM_DEPTH];
    pool_geom_pkg::pixel_t exp_q [$];
    string                 test_name;
    integer                seed;
    int                    result_cnt = 0;
    logic                  hold_prev;
    pool_geom_pkg::pixel_t held_data;

    tb_clk_gen #(.PERIOD_NS(8)) tb_clk_gen_i (.clk(clk));

    pool_engine #(
        .MAX_COLS (pool_geom_pkg::MAX_COLS)
    ) pool_engine_i (
        .clk             (clk),
        .rst             (rst),
        .opcode          (opcode),
        .opcode_valid    (opcode_valid),
        .opcode_accept   (opcode_accept),
        .opcode_complete (opcode_complete),
        .datain          (datain),
        .datain_valid    (datain_valid),
        .datain_ready    (datain_ready),
        .dataout         (dataout),
        .dataout_valid   (dataout_valid),
        .dataout_ready   (dataout_ready)
    );

    ////////////////////////////////////////////////////////////
    // Failure reporting and comparison
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
            abort_run("value mismatch");
        end
    endtask

    // Max of the 3x3 window for result res_idx of map map_idx
    function automatic pool_geom_pkg::pixel_t window_max(input int map_idx, input int res_idx,
                                                         input int rows, input int cols);
        int                    out_cols;
        int                    r0;
        int                    c0;
        int                    base;
        pool_geom_pkg::pixel_t best;
        out_cols = cols - 2;
        r0       = res_idx / out_cols;
        c0       = res_idx % out_cols;
        base     = map_idx * rows * cols;
        best     = '0;
        for (int dr = 0; dr < 3; dr++) begin
            for (int dc = 0; dc < 3; dc++) begin
                if (img_mem[base + (r0 + dr) * cols + c0 + dc] > best) begin
                    best = img_mem[base + (r0 + dr) * cols + c0 + dc];
                end
            end
        end
        return best;
    endfunction

    task automatic fill_images(input int total);
        for (int i = 0; i < total; i++) begin
            img_mem[i] = 16'($random(seed));
        end
    endtask

    task automatic check_idle_outputs();
        compare_value("opcode_accept idle", 0, opcode_accept);
        compare_value("opcode_complete idle", 0, opcode_complete);
        compare_value("datain_ready idle", 0, datain_ready);
        compare_value("dataout_valid idle", 0, dataout_valid);
    endtask

    // One-cycle opcode then accept expected three edges after sampling
    task automatic issue_opcode(input pool_ctrl_pkg::pool_op_e op, input int rows,
                                input int cols, input int maps);
        pool_ctrl_pkg::opcode_t word;
        int                     cnt;
        word.op_rsvd  = 4'd0;
        word.op       = op;
        word.rows     = pool_geom_pkg::dim_t'(rows);
        word.cols     = pool_geom_pkg::dim_t'(cols);
        word.num_maps = 8'(maps);
        opcode       <= word;
        opcode_valid <= 1'b1;
        @(posedge clk);
        opcode_valid <= 1'b0;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            compare_value("datain_ready before accept", 0, datain_ready);
            compare_value("opcode_complete before accept", 0, opcode_complete);
            if (cnt > OPCODE_TIMEOUT) begin
                abort_run("timed out waiting for opcode_accept");
            end
        end while (!opcode_accept);
        compare_value("accept latency", 3, cnt);
    endtask

    ////////////////////////////////////////////////////////////
    // Max-pool job with optional input gaps and output stalls
    ////////////////////////////////////////////////////////////

    task automatic run_pool_job(input string name, input int rows, input int cols,
                                input int maps, input bit stress, input bit new_data);
        int total;
        int sent;
        int cyc;
        int start_cnt;
        bit done;
        test_name = name;
        total     = maps * rows * cols;
        if (new_data) begin
            fill_images(total);
        end
        for (int m = 0; m < maps; m++) begin
            for (int i = 0; i < (rows - 2) * (cols - 2); i++) begin
                exp_q.push_back(window_max(m, i, rows, cols));
            end
        end
        start_cnt = result_cnt;
        issue_opcode(pool_ctrl_pkg::OP_MAX_POOL, rows, cols, maps);
        sent = 0;
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            if (sent < total) begin
                datain       <= img_mem[sent];
                datain_valid <= stress ? (($random(seed) & 3) != 0) : 1'b1;
            end else begin
                datain_valid <= 1'b0;
            end
            dataout_ready <= stress ? (($random(seed) & 7) > 2) : 1'b1;
            @(posedge clk);
            cyc++;
            // Accept is a single-cycle pulse
            compare_value("opcode_accept during job", 0, opcode_accept);
            if (datain_valid && datain_ready) begin
                sent++;
            end
            if (opcode_complete) begin
                done = 1'b1;
            end
            if (cyc > JOB_TIMEOUT) begin
                abort_run("timed out waiting for opcode_complete");
            end
        end
        compare_value("pixels taken", total, sent);
        compare_value("results left at completion", 0, exp_q.size());
        compare_value("result count", maps * (rows - 2) * (cols - 2), result_cnt - start_cnt);
        datain_valid  <= 1'b0;
        dataout_ready <= 1'b1;
        // Completion must not repeat
        repeat (8) begin
            @(posedge clk);
            compare_value("extra opcode_complete", 0, opcode_complete);
        end
    endtask

    task automatic run_nop_job();
        test_name = "nop";
        // Offered pixels must be ignored
        datain       <= 16'hbeef;
        datain_valid <= 1'b1;
        issue_opcode(pool_ctrl_pkg::OP_NOP, 8, 8, 1);
        @(posedge clk);
        compare_value("nop opcode_accept pulse", 0, opcode_accept);
        compare_value("nop opcode_complete", 1, opcode_complete);
        compare_value("nop datain_ready", 0, datain_ready);
        datain_valid <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            compare_value("nop late opcode_complete", 0, opcode_complete);
            compare_value("nop late datain_ready", 0, datain_ready);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            hold_prev <= 1'b0;
        end else begin
            // Stalled result stays offered and unchanged
            if (hold_prev) begin
                compare_value("dataout_valid held", 1, dataout_valid);
                compare_value("dataout held", held_data, dataout);
            end
            if (dataout_valid && dataout_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("result arrived with no result expected");
                end else begin
                    compare_value("window max", exp_q[0], dataout);
                    void'(exp_q.pop_front());
                    result_cnt++;
                end
            end
            hold_prev <= dataout_valid && !dataout_ready;
            held_data <= dataout;
        end
    end

    // Main sequence
    initial begin
        seed          = 60;
        test_name     = "reset";
        rst           = 1'b1;
        opcode        = '0;
        opcode_valid  = 1'b0;
        datain        = '0;
        datain_valid  = 1'b0;
        dataout_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst           <= 1'b0;
        dataout_ready <= 1'b1;
        repeat (6) begin
            @(posedge clk);
            check_idle_outputs();
        end
        run_pool_job("single_5x6", 5, 6, 1, 1'b0, 1'b1);
        run_pool_job("three_maps_8x8", 8, 8, 3, 1'b0, 1'b1);
        // Same images again now with gaps and stalls
        run_pool_job("three_maps_8x8_stalls", 8, 8, 3, 1'b1, 1'b0);
        run_nop_job();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: hw/pool_engine.sv
`timescale 1ns/1ns
`default_nettype none

module pool_engine #(
    parameter int MAX_COLS = pool_geom_pkg::MAX_COLS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  pool_ctrl_pkg::opcode_t opcode,
    input  logic                   opcode_valid,
    output logic                   opcode_accept,
    output logic                   opcode_complete,
    input  pool_geom_pkg::pixel_t  datain,
    input  logic                   datain_valid,
    output logic                   datain_ready,
    output pool_geom_pkg::pixel_t  dataout,
    output logic                   dataout_valid,
    input  logic                   dataout_ready
);

    // Last result of a map, back to the controller
    logic res_last;

    job_if job_bus ();
    win_if win_bus ();

    ////////////////////////////////////////////////////////////
    // Controller, line buffer, comparator tree
    ////////////////////////////////////////////////////////////

    pool_job_ctrl pool_job_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .opcode          (opcode),
        .opcode_valid    (opcode_valid),
        .opcode_accept   (opcode_accept),
        .opcode_complete (opcode_complete),
        .job             (job_bus),
        .res_last        (res_last)
    );

    pool_line_buffer #(
        .MAX_COLS (MAX_COLS)
    ) pool_line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .datain       (datain),
        .datain_valid (datain_valid),
        .datain_ready (datain_ready),
        .job          (job_bus),
        .win          (win_bus)
    );

    pool_max_tree pool_max_tree_i (
        .clk           (clk),
        .rst           (rst),
        .win           (win_bus),
        .dataout       (dataout),
        .dataout_valid (dataout_valid),
        .dataout_ready (dataout_ready),
        .res_last      (res_last)
    );

endmodule

`default_nettype wire

// File: hw/pool_max_tree.sv
`timescale 1ns/1ns
`default_nettype none

module pool_max_tree (
    input  logic                  clk,
    input  logic                  rst,
    win_if.dst                    win,
    output pool_geom_pkg::pixel_t dataout,
    output logic                  dataout_valid,
    input  logic                  dataout_ready,
    output logic                  res_last
);

    pool_geom_pkg::pixel_t s1_max [pool_geom_pkg::KERNEL_DIM];
    logic                  s1_valid;
    logic                  s1_last;
    pool_geom_pkg::pixel_t s2_max01;
    pool_geom_pkg::pixel_t s2_row2;
    logic                  s2_valid;
    logic                  s2_last;
    pool_geom_pkg::pixel_t s3_max;
    logic                  s3_valid;
    logic                  s3_last;

    function automatic pool_geom_pkg::pixel_t max2(input pool_geom_pkg::pixel_t a,
                                                   input pool_geom_pkg::pixel_t b);
        return (a > b) ? a : b;
    endfunction

    // Whole pipe freezes when the sink is not ready
    assign win.stall = !dataout_ready;

    ////////////////////////////////////////////////////////////
    // Three comparator stages
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (dataout_ready) begin
            // Stage 1, per-row max
            for (int r = 0; r < pool_geom_pkg::KERNEL_DIM; r++) begin
                s1_max[r] <= max2(max2(win.win[r][0], win.win[r][1]), win.win[r][2]);
            end
            s1_last  <= win.win_last;
            // Stage 2, rows 0 and 1 merged, row 2 rides along
            s2_max01 <= max2(s1_max[0], s1_max[1]);
            s2_row2  <= s1_max[2];
            s2_last  <= s1_last;
            // Stage 3, final max
            s3_max   <= max2(s2_max01, s2_row2);
            s3_last  <= s2_last;
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (dataout_ready) begin
            s1_valid <= win.win_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    assign dataout       = s3_max;
    assign dataout_valid = s3_valid;
    // Final result of a map leaving
    assign res_last      = s3_valid && s3_last && dataout_ready;

    // Offered result holds until taken
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (dataout_valid && !dataout_ready) |=> (dataout_valid && $stable(dataout)));

endmodule

`default_nettype wire

// File: hw/pool_line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module pool_line_buffer #(
    parameter int MAX_COLS = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  pool_geom_pkg::pixel_t datain,
    input  logic                  datain_valid,
    output logic                  datain_ready,
    job_if.lbuf                   job,
    win_if.src                    win
);

    localparam int AW = $clog2(MAX_COLS);
    // Index of the last window column and row
    localparam pool_geom_pkg::dim_t EDGE = pool_geom_pkg::dim_t'(pool_geom_pkg::KERNEL_DIM - 1);

    // Previous row and the one before it
    pool_geom_pkg::pixel_t      row1_mem [MAX_COLS];
    pool_geom_pkg::pixel_t      row2_mem [MAX_COLS];
    pool_geom_pkg::window_t     win_r;
    pool_ctrl_pkg::fill_state_e fill;
    pool_geom_pkg::dim_t        col_cnt;
    pool_geom_pkg::dim_t        row_cnt;
    logic [AW-1:0]              addr;
    logic                       xfer;
    logic                       col_end;
    logic                       row_end;
    logic                       win_done;
    logic                       map_done;
    logic                       win_pend;
    logic                       last_pend;

    // No intake between maps or while the output is blocked
    assign datain_ready = job.active && !win.stall && !job.map_start && !map_done;
    assign xfer         = datain_valid && datain_ready;
    assign addr         = col_cnt[AW-1:0];

    assign col_end  = (col_cnt == job.cols - 8'd1);
    assign row_end  = (row_cnt == job.rows - 8'd1);
    // This pixel closes a full 3x3 window
    assign win_done = xfer && (fill == pool_ctrl_pkg::ST_ACTIVE) && (col_cnt >= EDGE);

    ////////////////////////////////////////////////////////////
    // Row memories and window shift
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (xfer) begin
            // Each column slot ages by one row
            row1_mem[addr] <= datain;
            row2_mem[addr] <= row1_mem[addr];
            // Shift left one column
            for (int r = 0; r < pool_geom_pkg::KERNEL_DIM; r++) begin
                win_r[r][0] <= win_r[r][1];
                win_r[r][1] <= win_r[r][2];
            end
            // New column enters on the right with the oldest row on top
            win_r[0][2] <= row2_mem[addr];
            win_r[1][2] <= row1_mem[addr];
            win_r[2][2] <= datain;
        end
        if (win_done) begin
            last_pend <= row_end && col_end;
        end
    end

    ////////////////////////////////////////////////////////////
    // Position counters and fill tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            fill     <= pool_ctrl_pkg::ST_FILL;
            map_done <= 1'b0;
            win_pend <= 1'b0;
        end else begin
            if (job.map_start) begin
                col_cnt  <= '0;
                row_cnt  <= '0;
                fill     <= pool_ctrl_pkg::ST_FILL;
                map_done <= 1'b0;
            end else if (xfer) begin
                if (col_end) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 8'd1;
                    // First two rows now in memory
                    if (row_cnt == EDGE - 8'd1) begin
                        fill <= pool_ctrl_pkg::ST_ACTIVE;
                    end
                    // Last pixel of the map holds off intake until next map_start
                    if (row_end) begin
                        map_done <= 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 8'd1;
                end
            end
            // Window waits here until the tree can take it
            if (win_done) begin
                win_pend <= 1'b1;
            end else if (!win.stall) begin
                win_pend <= 1'b0;
            end
        end
    end

    assign win.win       = win_r;
    assign win.win_valid = win_pend && !win.stall;
    assign win.win_last  = last_pend;

    // A window held back by a stall stays pending and unchanged
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (win_pend && win.stall)
            |=> (win_pend && $stable(win.win) && $stable(win.win_last)));

endmodule

`default_nettype wire

// File: hw/pool_job_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module pool_job_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  pool_ctrl_pkg::opcode_t opcode,
    input  logic                   opcode_valid,
    output logic                   opcode_accept,
    output logic                   opcode_complete,
    job_if.ctrl                    job,
    input  logic                   res_last
);

    localparam pool_geom_pkg::dim_t MIN_DIM = pool_geom_pkg::dim_t'(pool_geom_pkg::KERNEL_DIM);

    pool_ctrl_pkg::job_state_e state;
    pool_ctrl_pkg::opcode_t    opcode_r;
    logic [7:0]                map_cnt;
    logic                      is_pool;
    logic                      last_map;

    // Geometry straight from the held opcode
    assign job.rows = opcode_r.rows;
    assign job.cols = opcode_r.cols;

    // Pool only with clean op byte, at least one map and room for a window
    assign is_pool = (opcode_r.op_rsvd == 4'd0)
                  && (opcode_r.op == pool_ctrl_pkg::OP_MAX_POOL)
                  && (opcode_r.num_maps != 8'd0)
                  && (opcode_r.rows >= MIN_DIM)
                  && (opcode_r.cols >= MIN_DIM);

    assign last_map = (map_cnt == opcode_r.num_maps - 8'd1);

    // Opcode capture in idle
    always_ff @(posedge clk) begin
        if (state == pool_ctrl_pkg::ST_IDLE && opcode_valid) begin
            opcode_r <= opcode;
        end
    end

    ////////////////////////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= pool_ctrl_pkg::ST_IDLE;
            opcode_accept   <= 1'b0;
            opcode_complete <= 1'b0;
            job.active      <= 1'b0;
            job.map_start   <= 1'b0;
            map_cnt         <= 8'd0;
        end else begin
            // Pulses default low
            opcode_accept   <= 1'b0;
            opcode_complete <= 1'b0;
            job.map_start   <= 1'b0;
            case (state)
                pool_ctrl_pkg::ST_IDLE: begin
                    if (opcode_valid) begin
                        state <= pool_ctrl_pkg::ST_LOAD;
                    end
                end
                pool_ctrl_pkg::ST_LOAD: begin
                    state <= pool_ctrl_pkg::ST_DECODE;
                end
                pool_ctrl_pkg::ST_DECODE: begin
                    opcode_accept <= 1'b1;
                    map_cnt       <= 8'd0;
                    // First map kicked off together with the accept
                    job.active    <= is_pool;
                    job.map_start <= is_pool;
                    state         <= pool_ctrl_pkg::ST_BUSY;
                end
                pool_ctrl_pkg::ST_BUSY: begin
                    if (!job.active) begin
                        // Nothing to stream so done right away
                        opcode_complete <= 1'b1;
                        state           <= pool_ctrl_pkg::ST_IDLE;
                    end else if (res_last) begin
                        if (last_map) begin
                            opcode_complete <= 1'b1;
                            job.active      <= 1'b0;
                            state           <= pool_ctrl_pkg::ST_IDLE;
                        end else begin
                            // Next map
                            map_cnt       <= map_cnt + 8'd1;
                            job.map_start <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= pool_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Accept only ever follows an opcode sampled in idle three cycles before
    a_accept_after_opcode: assert property (@(posedge clk) disable iff (rst)
        opcode_accept |-> $past(opcode_valid, 3)
                       && ($past(state, 3) == pool_ctrl_pkg::ST_IDLE));

endmodule

`default_nettype wire

// File: hw/pool_ifs.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////
// Controller to line buffer
////////////////////////////////////////////////////////////

interface job_if;
    // Geometry, held for the whole job
    pool_geom_pkg::dim_t rows;
    pool_geom_pkg::dim_t cols;
    // High while a max-pool job runs
    logic                active;
    // One-cycle pulse ahead of each map
    logic                map_start;

    modport ctrl (output rows, cols, active, map_start);
    modport lbuf (input rows, cols, active, map_start);
endinterface

////////////////////////////////////////////////////////////
// Line buffer to comparator tree
////////////////////////////////////////////////////////////

interface win_if;
    pool_geom_pkg::window_t win;
    // Strobe, once per complete window
    logic                   win_valid;
    // Marks final window of a map
    logic                   win_last;
    // Back-pressure from the output side
    logic                   stall;

    modport src (output win, win_valid, win_last, input stall);
    modport dst (input win, win_valid, win_last, output stall);
endinterface

`default_nettype wire

// File: hw/pool_ctrl_pkg.sv
`default_nettype none

package pool_ctrl_pkg;

    // Operation codes
    typedef enum logic [3:0] {
        OP_NOP      = 4'h0,
        OP_MAX_POOL = 4'h1
    } pool_op_e;

    ////////////////////////////////////////////////////////////
    // Opcode word, 32 bits
    ////////////////////////////////////////////////////////////

    // Upper nibble of the op byte is reserved, must be zero
    typedef struct packed {
        logic [3:0]          op_rsvd;
        pool_op_e            op;
        pool_geom_pkg::dim_t rows;
        pool_geom_pkg::dim_t cols;
        logic [7:0]          num_maps;
    } opcode_t;

    // Job controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DECODE,
        ST_BUSY
    } job_state_e;

    // Line buffer fill tracking
    typedef enum logic {
        ST_FILL,
        ST_ACTIVE
    } fill_state_e;

endpackage

`default_nettype wire

// File: hw/pool_geom_pkg.sv
`default_nettype none

package pool_geom_pkg;

    ////////////////////////////////////////////////////////////
    // Sample and window geometry
    ////////////////////////////////////////////////////////////

    // One image sample, compared as unsigned
    typedef logic [15:0] pixel_t;

    // Side of the square pooling window
    localparam int KERNEL_DIM = 3;

    // Window indexed [row][col], row 0 oldest, col 2 newest
    typedef pixel_t [KERNEL_DIM-1:0][KERNEL_DIM-1:0] window_t;

    // Widest supported image, sets row memory depth
    localparam int MAX_COLS = 64;

    // Image height or width in pixels
    typedef logic [7:0] dim_t;

endpackage

`default_nettype wire
